// File: Bender.yml
package:
  name: rv_exec_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/rv_decoder.sv
      - src/op_queue.sv
      - src/rv_executor.sv
      - src/rv_exec_core.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - tests/tb_rv_exec_core.sv

// File: all.f
+incdir+src
src/rv_pkg.sv
src/rv_decoder.sv
src/op_queue.sv
src/rv_executor.sv
src/rv_exec_core.sv
tests/tb_rv_exec_core.sv

// File: src/op_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular FIFO of decoded ops between decoder and executor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module op_queue import rv_pkg::*; #(
  parameter int DEPTH = `RV_OP_QUEUE_DEPTH
) (
  input  logic        clock,
  input  logic        reset_n,
  input  logic        push,
  input  decoded_op_t push_op,
  input  logic        pop,
  output decoded_op_t head_op,
  output logic        full,
  output logic        empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  decoded_op_t        slots [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign head_op = slots[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) slots[wr_ptr] <= push_op;
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;  // Both leaves count as is
    end
  end

endmodule

`default_nettype wire

// File: src/rv_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, RV32I opcodes and function codes for the execution engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN            32
`define RV_REG_ADDR_W      5
`define RV_OP_QUEUE_DEPTH  4

`define OP_REG     7'b0110011
`define OP_IMM     7'b0010011
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_BRANCH  7'b1100011

`define F7_BASE    7'b0000000  // ADD, SRL and the rest
`define F7_ALT     7'b0100000  // SUB and SRA
`define F3_ADD     3'b000
`define F3_SLL     3'b001
`define F3_SR      3'b101      // SRL or SRA by funct7

`define F3_BEQ     3'b000
`define F3_BNE     3'b001
`define F3_BLT     3'b100
`define F3_BGE     3'b101
`define F3_BLTU    3'b110
`define F3_BGEU    3'b111

`endif

// File: src/rv_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input req/ack port and RV32I decode into queue records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_decoder import rv_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,
  input  logic        in_req,
  input  instr_in_t   in_instr,
  output logic        in_ack,
  input  logic        full,
  output logic        push,
  output decoded_op_t op
);

  instr_word_u          word;
  logic [`RV_XLEN-1:0]  imm_i;
  logic [`RV_XLEN-1:0]  imm_u;
  logic [`RV_XLEN-1:0]  imm_b;
  logic [`RV_XLEN-1:0]  imm_j;
  logic                 reg_ok;
  logic                 imm_ok;

  assign word  = in_instr.instr;
  assign imm_i = {{20{word.i.imm12[11]}}, word.i.imm12};
  assign imm_u = {word.i.imm12, word.i.rs1, word.i.funct3, 12'b0};
  assign imm_b = {{20{word.r.funct7[6]}}, word.r.rd[0], word.r.funct7[5:0],
                  word.r.rd[4:1], 1'b0};
  assign imm_j = {{12{word.i.imm12[11]}}, word.i.rs1, word.i.funct3,
                  word.i.imm12[0], word.i.imm12[10:1], 1'b0};

  // Only SUB and SRA may use the alternate funct7
  assign reg_ok = (word.r.funct7 == `F7_BASE) ||
                  ((word.r.funct7 == `F7_ALT) &&
                   ((word.r.funct3 == `F3_ADD) || (word.r.funct3 == `F3_SR)));
  assign imm_ok = (word.r.funct3 == `F3_SLL) ? (word.r.funct7 == `F7_BASE) :
                  (word.r.funct3 == `F3_SR)  ? ((word.r.funct7 == `F7_BASE) ||
                                                (word.r.funct7 == `F7_ALT)) : 1'b1;

  assign push = in_req && !in_ack && !full;  // Accept edge

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      in_ack <= 1'b0;
    end else if (push) begin
      in_ack <= 1'b1;
    end else if (!in_req) begin
      in_ack <= 1'b0;
    end
  end

  always_comb begin
    op         = '0;
    op.pc      = in_instr.pc;
    op.rs1     = word.r.rs1;
    op.rs2     = word.r.rs2;
    op.rd      = word.r.rd;
    op.funct3  = word.r.funct3;
    op.alu_op  = ALU_ADD;
    op.op2_imm = 1'b1;
    op.imm     = imm_i;
    case (word.r.opcode)
      `OP_REG: begin
        op.alu_op    = alu_op_e'({word.r.funct7[5], word.r.funct3});
        op.op2_imm   = 1'b0;
        op.writes_rd = 1'b1;
        op.illegal   = !reg_ok;
      end
      `OP_IMM: begin
        op.alu_op    = (word.r.funct3 == `F3_SR) ?
                       alu_op_e'({word.r.funct7[5], word.r.funct3}) :
                       alu_op_e'({1'b0, word.r.funct3});
        op.writes_rd = 1'b1;
        op.illegal   = !imm_ok;
      end
      `OP_LUI: begin
        op.rs1       = '0;  // x0 plus upper immediate
        op.imm       = imm_u;
        op.writes_rd = 1'b1;
      end
      `OP_AUIPC: begin
        op.op1_pc    = 1'b1;
        op.imm       = imm_u;
        op.writes_rd = 1'b1;
      end
      `OP_JAL: begin
        op.op1_pc    = 1'b1;
        op.imm       = imm_j;
        op.jump      = 1'b1;
        op.writes_rd = 1'b1;
      end
      `OP_JALR: begin
        op.jump      = 1'b1;
        op.writes_rd = 1'b1;
        op.illegal   = (word.r.funct3 != `F3_ADD);
      end
      `OP_BRANCH: begin
        op.op1_pc    = 1'b1;  // ALU forms the target
        op.imm       = imm_b;
        op.branch    = 1'b1;
        op.illegal   = (word.r.funct3 == 3'b010) || (word.r.funct3 == 3'b011);
      end
      default: op.illegal = 1'b1;  // Loads, stores, system, MUL/DIV
    endcase
    if (op.illegal) begin
      op.writes_rd = 1'b0;
      op.branch    = 1'b0;
      op.jump      = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/rv_exec_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Engine top: decoder feeds the op queue, executor drains it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core import rv_pkg::*; (
  input  logic         clock,
  input  logic         reset_n,
  input  logic         in_req,
  input  instr_in_t    in_instr,
  output logic         in_ack,
  output logic         out_req,
  input  logic         out_ack,
  output exec_result_t out_result
);

  logic         push;
  logic         pop;
  logic         full;
  logic         empty;
  decoded_op_t  dec_op;   // Decoder to queue
  decoded_op_t  head_op;  // Queue to executor

  rv_decoder u_decoder (
    .clock    (clock),
    .reset_n  (reset_n),
    .in_req   (in_req),
    .in_instr (in_instr),
    .in_ack   (in_ack),
    .full     (full),
    .push     (push),
    .op       (dec_op)
  );

  op_queue u_queue (
    .clock    (clock),
    .reset_n  (reset_n),
    .push     (push),
    .push_op  (dec_op),
    .pop      (pop),
    .head_op  (head_op),
    .full     (full),
    .empty    (empty)
  );

  rv_executor u_executor (
    .clock      (clock),
    .reset_n    (reset_n),
    .empty      (empty),
    .head_op    (head_op),
    .pop        (pop),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_result (out_result)
  );

endmodule

`default_nettype wire

// File: src/rv_executor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file, ALU and branch unit; results leave on a req/ack port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_executor import rv_pkg::*; (
  input  logic         clock,
  input  logic         reset_n,
  input  logic         empty,
  input  decoded_op_t  head_op,
  output logic         pop,
  output logic         out_req,
  input  logic         out_ack,
  output exec_result_t out_result
);

  logic [`RV_XLEN-1:0]  regs [2**`RV_REG_ADDR_W];
  logic [`RV_XLEN-1:0]  rs1_val;
  logic [`RV_XLEN-1:0]  rs2_val;
  logic [`RV_XLEN-1:0]  op1;
  logic [`RV_XLEN-1:0]  op2;
  logic [`RV_XLEN-1:0]  alu_out;
  logic [`RV_XLEN-1:0]  pc_plus4;
  logic                 cond;
  logic                 start;
  exec_result_t         res;

  function automatic logic [`RV_XLEN-1:0] alu_exec(input alu_op_e alu_op,
                                                   input logic [`RV_XLEN-1:0] a,
                                                   input logic [`RV_XLEN-1:0] b);
    case (alu_op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? `RV_XLEN'(1) : '0;
      ALU_SLTU: return (a < b) ? `RV_XLEN'(1) : '0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_cond(input logic [2:0] funct3,
                                       input logic [`RV_XLEN-1:0] a,
                                       input logic [`RV_XLEN-1:0] b);
    case (funct3)
      `F3_BEQ:  return a == b;
      `F3_BNE:  return a != b;
      `F3_BLT:  return $signed(a) < $signed(b);
      `F3_BGE:  return $signed(a) >= $signed(b);
      `F3_BLTU: return a < b;
      `F3_BGEU: return a >= b;
      default:  return 1'b0;
    endcase
  endfunction

  // x0 is hardwired
  assign rs1_val = (head_op.rs1 == '0) ? '0 : regs[head_op.rs1];
  assign rs2_val = (head_op.rs2 == '0) ? '0 : regs[head_op.rs2];

  assign op1      = head_op.op1_pc  ? head_op.pc  : rs1_val;
  assign op2      = head_op.op2_imm ? head_op.imm : rs2_val;
  assign alu_out  = alu_exec(head_op.alu_op, op1, op2);
  assign pc_plus4 = head_op.pc + `RV_XLEN'(4);
  assign cond     = branch_cond(head_op.funct3, rs1_val, rs2_val);

  always_comb begin
    res.rd      = head_op.rd;
    res.value   = head_op.jump ? pc_plus4 : alu_out;  // Link value for JAL/JALR
    res.wen     = head_op.writes_rd && (head_op.rd != '0);
    res.taken   = head_op.jump || (head_op.branch && cond);
    res.illegal = head_op.illegal;
    res.next_pc = res.taken ? {alu_out[`RV_XLEN-1:1], 1'b0} : pc_plus4;
  end

  // New op only when the previous result is fully acknowledged
  assign start = !empty && !out_req && !out_ack;
  assign pop   = start;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      out_req <= 1'b0;
    end else if (start) begin
      out_req <= 1'b1;
    end else if (out_req && out_ack) begin
      out_req <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start) out_result <= res;
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 2**`RV_REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (start && res.wen) begin
      regs[res.rd] <= res.value;
    end
  end

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the decoder, op queue and executor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

  typedef struct packed {
    logic [6:0]                  funct7;
    logic [`RV_REG_ADDR_W-1:0]   rs2;
    logic [`RV_REG_ADDR_W-1:0]   rs1;
    logic [2:0]                  funct3;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [6:0]                  opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0]                 imm12;  // Also upper bits of the U immediate
    logic [`RV_REG_ADDR_W-1:0]   rs1;
    logic [2:0]                  funct3;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [6:0]                  opcode;
  } instr_i_t;

  // Same word, two field layouts
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_word_u;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef struct packed {
    instr_word_u                 instr;
    logic [`RV_XLEN-1:0]         pc;
  } instr_in_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]         pc;
    logic [`RV_XLEN-1:0]         imm;        // Sign-extended
    logic [`RV_REG_ADDR_W-1:0]   rs1;
    logic [`RV_REG_ADDR_W-1:0]   rs2;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    alu_op_e                     alu_op;
    logic                        op1_pc;     // Op1 is pc, else rs1
    logic                        op2_imm;    // Op2 is imm, else rs2
    logic [2:0]                  funct3;
    logic                        branch;
    logic                        jump;
    logic                        writes_rd;
    logic                        illegal;
  } decoded_op_t;

  typedef struct packed {
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [`RV_XLEN-1:0]         value;
    logic                        wen;
    logic                        taken;
    logic                        illegal;
    logic [`RV_XLEN-1:0]         next_pc;
  } exec_result_t;

endpackage

`default_nettype wire

// File: tests/tb_rv_exec_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the execution engine: RV32I model, LFSR operands, slow sink
// Results are checked in order against the model by concurrent assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module tb_rv_exec_core import rv_pkg::*;;

  localparam int NUM_INSTR = 100;  // Issued over all tests
  localparam int MAX_DELAY = 11;   // Longest sink delay in cycles
  localparam int TIMEOUT   = NUM_INSTR * (MAX_DELAY + 8) + 200;

  logic         clock = 1'b0;
  logic         reset_n;
  logic         in_req;
  instr_in_t    in_instr;
  logic         in_ack;
  logic         out_req;
  logic         out_ack;
  exec_result_t out_result;

  logic [15:0]  lfsr = 16'd74;
  logic [31:0]  model_regs [32] = '{default: 32'h0};
  logic [31:0]  src_pc = 32'h0000_1000;
  exec_result_t exp_q [$];
  exec_result_t mask_q [$];
  int           delay_q [$];
  exec_result_t exp_head = '0;
  exec_result_t exp_mask = '1;
  logic         sink_slow = 1'b0;
  logic         saw_stall = 1'b0;
  int           cycles = 0;
  int           err_count = 0;
  int           errs_at_start;
  int           pass_count = 0;
  int           fail_count = 0;
  int           test_num = 0;
  int           sent = 0;
  int           received = 0;

  rv_exec_core DUT (
    .clock      (clock),
    .reset_n    (reset_n),
    .in_req     (in_req),
    .in_instr   (in_instr),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_result (out_result)
  );

  always #20 clock = ~clock;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OP_REG};
  endfunction

  function automatic logic [31:0] encode_i(input logic [6:0] op, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encode_u(input logic [6:0] op, input logic [19:0] imm,
                                           input logic [4:0] rd);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
  endfunction

  function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> sh;
        return a >> sh;
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    logic hit;
    case (f3[2:1])
      2'b00:   hit = (a == b);
      2'b10:   hit = $signed(a) < $signed(b);
      default: hit = a < b;
    endcase
    return hit ^ f3[0];  // Odd codes negate
  endfunction

  // Expected result from the RV32I rules; care is low when value is undefined
  function automatic exec_result_t predict(input logic [31:0] w, input logic [31:0] pc,
                                           output logic care);
    exec_result_t r;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  imm_i;
    logic [31:0]  imm_u;
    logic [31:0]  imm_b;
    logic [31:0]  imm_j;
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'b0};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    r         = '0;
    r.rd      = w[11:7];
    r.next_pc = pc + 32'd4;
    care      = 1'b1;
    case (w[6:0])
      `OP_REG:   r.value = alu_ref(w[14:12], w[30], a, b);
      `OP_IMM:   r.value = alu_ref(w[14:12], w[30] && (w[14:12] == 3'd5), a, imm_i);
      `OP_LUI:   r.value = imm_u;
      `OP_AUIPC: r.value = pc + imm_u;
      `OP_JAL: begin
        r.value   = pc + 32'd4;
        r.taken   = 1'b1;
        r.next_pc = (pc + imm_j) & ~32'd1;
      end
      `OP_JALR: begin
        r.value   = pc + 32'd4;
        r.taken   = 1'b1;
        r.next_pc = (a + imm_i) & ~32'd1;  // Low bit dropped
      end
      `OP_BRANCH: begin
        r.value = pc + imm_b;
        r.taken = branch_ref(w[14:12], a, b);
        if (r.taken) r.next_pc = pc + imm_b;
      end
      default: begin
        r.illegal = 1'b1;
        care      = 1'b0;
      end
    endcase
    r.wen = !r.illegal && (w[6:0] != `OP_BRANCH) && (r.rd != 5'd0);
    return r;
  endfunction

  task automatic refresh_head();
    if (exp_q.size() > 0) begin
      exp_head = exp_q[0];
      exp_mask = mask_q[0];
    end else begin
      exp_head = '0;
      exp_mask = '1;
    end
  endtask

  // Four-phase send of one word; the model runs ahead in issue order
  task automatic issue(input logic [31:0] w);
    exec_result_t r;
    exec_result_t m;
    logic         care;
    r = predict(w, src_pc, care);
    m = '1;
    if (!care) m.value = '0;
    if (r.wen) model_regs[r.rd] = r.value;
    exp_q.push_back(r);
    mask_q.push_back(m);
    delay_q.push_back(sink_slow ? 4 + int'(rand_bits(3)) : 0);
    refresh_head();
    @(posedge clock);
    in_req   <= 1'b1;
    in_instr <= {w, src_pc};
    do @(posedge clock); while (!in_ack);
    in_req <= 1'b0;
    do @(posedge clock); while (in_ack);
    src_pc = src_pc + 32'd4;
    sent++;
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = v + 32'h800;  // ADDI sign-extends the low 12 bits
    issue(encode_u(`OP_LUI, upper[31:12], rd));
    issue(encode_i(`OP_IMM, v[11:0], rd, `F3_ADD, rd));
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || out_req || out_ack) @(posedge clock);
  endtask

  task automatic start_test();
    test_num++;
    errs_at_start = err_count;
  endtask

  task automatic end_test(input string name);
    wait_drain();
    if (err_count == errs_at_start) begin
      pass_count++;
      $display("[pass] test %0d: %s", test_num, name);
    end else begin
      fail_count++;
      $display("[fail] test %0d: %s", test_num, name);
    end
  endtask

  // Sink side, acks each result after the delay drawn at issue
  initial begin : sink
    int d;
    forever begin
      @(posedge clock);
      if (out_req && !out_ack) begin
        d = 0;
        if (delay_q.size() > 0) begin
          d = delay_q.pop_front();
        end else begin
          err_count++;
          $display("Result at %0d ns arrived with no instruction outstanding", $time);
        end
        repeat (d) @(posedge clock);
        out_ack <= 1'b1;
        received++;
        do @(posedge clock); while (out_req);
        out_ack <= 1'b0;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
          void'(mask_q.pop_front());
        end
        refresh_head();
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (in_req && !in_ack && DUT.full) saw_stall <= 1'b1;  // Back-pressure seen
    if (cycles == TIMEOUT) begin
      $display("Run stopped after %0d cycles with results still outstanding", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  ack_rise: assert property (@(posedge clock) disable iff (!reset_n)
    (in_req && !in_ack && !DUT.full) |=> in_ack)
    else begin
      err_count++;
      $display("** Error at %0d ns: in_ack = %b, expected 1", $time, in_ack);
    end

  ack_hold: assert property (@(posedge clock) disable iff (!reset_n)
    (!in_ack && DUT.full) |=> !in_ack)
    else begin
      err_count++;
      $display("** Error at %0d ns: in_ack = %b, expected 0", $time, in_ack);
    end

  ack_fall: assert property (@(posedge clock) disable iff (!reset_n)
    !in_req |=> !in_ack)
    else begin
      err_count++;
      $display("** Error at %0d ns: in_ack = %b, expected 0", $time, in_ack);
    end

  req_rise: assert property (@(posedge clock) disable iff (!reset_n)
    (!out_req && !out_ack && !DUT.empty) |=> out_req)
    else begin
      err_count++;
      $display("** Error at %0d ns: out_req = %b, expected 1", $time, out_req);
    end

  req_fall: assert property (@(posedge clock) disable iff (!reset_n)
    out_ack |=> !out_req)
    else begin
      err_count++;
      $display("** Error at %0d ns: out_req = %b, expected 0", $time, out_req);
    end

  result_match: assert property (@(posedge clock) disable iff (!reset_n)
    (out_req && !out_ack) |-> ((out_result & exp_mask) == (exp_head & exp_mask)))
    else begin
      err_count++;
      $display("** Error at %0d ns: out_result = %h, expected %h",
               $time, out_result, exp_head);
    end

  initial begin : main
    logic [31:0] v0;
    logic [31:0] v1;
    logic [2:0]  br_f3 [6];
    reset_n  = 1'b0;
    in_req   = 1'b0;
    in_instr = '0;
    out_ack  = 1'b0;
    br_f3    = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
    repeat (8) @(posedge clock);
    reset_n <= 1'b1;
    @(posedge clock);

    start_test();
    idle_check: assert (!in_ack && !out_req)
      else begin
        err_count++;
        $display("Handshake outputs were not idle after reset");
      end
    issue(encode_i(`OP_IMM, 12'hf9c, 5'd0, `F3_ADD, 5'd3));  // ADDI x3, x0, -100
    end_test("reset state and ADDI from x0");

    start_test();
    for (int round = 0; round < 2; round++) begin
      // Second round forces opposite signs so SLT and SLTU differ
      load_reg(5'd1, rand_bits(32) | ((round == 1) ? 32'h8000_0000 : 32'h0));
      load_reg(5'd2, rand_bits(32) & ((round == 1) ? 32'h7fff_ffff : 32'hffff_ffff));
      for (int f = 0; f < 8; f++) begin
        issue(encode_r(`F7_BASE, 5'd2, 5'd1, 3'(f), 5'(10 + f)));
        if (f == 0 || f == 5) issue(encode_r(`F7_ALT, 5'd2, 5'd1, 3'(f), 5'(20 + f)));
        if (f == 1 || f == 5) begin
          issue(encode_i(`OP_IMM, {7'b0, 5'(rand_bits(5))}, 5'd1, 3'(f), 5'd18));
          if (f == 5) begin
            issue(encode_i(`OP_IMM, {`F7_ALT, 5'(rand_bits(5))}, 5'd1, 3'(f), 5'd19));
          end
        end else begin
          issue(encode_i(`OP_IMM, 12'(rand_bits(12)), 5'd1, 3'(f), 5'd18));
        end
      end
    end
    end_test("R-type and I-type ALU operations");

    start_test();
    issue(encode_i(`OP_IMM, 12'd123, 5'd1, `F3_ADD, 5'd0));    // Write to x0 dropped
    issue(encode_r(`F7_BASE, 5'd0, 5'd0, `F3_ADD, 5'd4));      // Reads x0 back
    issue(32'h0000_a283);                                      // LW x5, 0(x1)
    issue(32'h0000_0073);                                      // ECALL
    issue(encode_r(`F7_BASE, 5'd0, 5'd5, `F3_ADD, 5'd6));      // x5 still zero
    end_test("x0 writes and illegal opcodes");

    start_test();
    load_reg(5'd1, rand_bits(32) & ~32'd1);
    issue(encode_u(`OP_LUI, 20'(rand_bits(20)), 5'd5));
    issue(encode_u(`OP_AUIPC, 20'(rand_bits(20)), 5'd6));
    issue(encode_j({20'(rand_bits(20)), 1'b0}, 5'd7));
    issue(encode_i(`OP_JALR, {11'(rand_bits(11)), 1'b1}, 5'd1, `F3_ADD, 5'd8));  // Odd target
    end_test("LUI, AUIPC, JAL and JALR");

    start_test();
    v0 = rand_bits(32);
    v1 = rand_bits(32);
    for (int s = 0; s < 3; s++) begin
      load_reg(5'd1, (s == 2) ? v1 : v0);
      load_reg(5'd2, (s == 1) ? v1 : v0);
      for (int k = 0; k < 6; k++) begin
        issue(encode_b({12'(rand_bits(12)), 1'b0}, 5'd2, 5'd1, br_f3[k]));
      end
    end
    end_test("conditional branches taken and not taken");

    start_test();
    sink_slow = 1'b1;
    for (int n = 0; n < 12; n++) begin
      if (n % 2 == 0) begin
        issue(encode_i(`OP_IMM, 12'(rand_bits(12)), 5'(rand_bits(5)), `F3_ADD,
                       5'(rand_bits(5))));
      end else begin
        issue(encode_r(`F7_BASE, 5'(rand_bits(5)), 5'(rand_bits(5)), `F3_ADD,
                       5'(rand_bits(5))));
      end
    end
    wait_drain();
    stall_seen: assert (saw_stall)
      else begin
        err_count++;
        $display("The input port never stalled while the queue was full");
      end
    count_check: assert (sent == received)
      else begin
        err_count++;
        $display("%0d instructions were sent but %0d results came back", sent, received);
      end
    end_test("burst with a slow sink");

    $display("Summary: %0d tests passed, %0d failed, %0d check errors",
             pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
